// File: sim.f
verilog/vec_pkg.sv
verilog/vec_dispatcher.sv
verilog/vec_lane.sv
verilog/vec_collector.sv
verilog/vec_system.sv
testbench/tb_vec_system.sv

// File: Bender.yml
package:
  name: vec_system

sources:
  - files:
      - verilog/vec_pkg.sv
      - verilog/vec_dispatcher.sv
      - verilog/vec_lane.sv
      - verilog/vec_collector.sv
      - verilog/vec_system.sv

  - target: simulation
    files:
      - testbench/tb_vec_system.sv

// File: testbench/tb_vec_system.sv
`timescale 1ns/1ps

module tb_vec_system;

  import vec_pkg::*;

  localparam int unsigned NUM_TESTS      = 21;
  localparam int unsigned RESET_CYCLES   = 5;
  localparam int unsigned LAT_LEGAL      = ELEMS_PER_LANE + 2;
  localparam int unsigned LAT_ILLEGAL    = 1;
  localparam int unsigned TIMEOUT_CYCLES = NUM_TESTS * 12 + RESET_CYCLES;
  localparam int unsigned VAL_W          = 64;

  typedef struct packed {
    acc_req_t         req;
    logic [ELEN-1:0]  exp_result;
    logic             exp_err;
  } tb_entry_t;

  logic         clk_i;
  logic         rst_n_i;
  logic         req_valid_i;
  acc_req_t     req_i;
  logic         req_ready_o;
  logic         resp_valid_o;
  acc_resp_t    resp_o;
  logic         resp_ready_i;

  tb_entry_t    tbl [NUM_TESTS];
  logic [31:0]  lfsr_q;
  int unsigned  errors;
  int unsigned  failed_tests;
  int unsigned  cycle_cnt;

  vec_system DUT (
    .clk_i        (clk_i       ),
    .rst_n_i      (rst_n_i     ),
    .req_valid_i  (req_valid_i ),
    .req_i        (req_i       ),
    .req_ready_o  (req_ready_o ),
    .resp_valid_o (resp_valid_o),
    .resp_o       (resp_o      ),
    .resp_ready_i (resp_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Two bits, one step each
  task automatic pick_delay(output int unsigned d);
    d = 0;
    for (int b = 0; b < 2; b++) begin
      lfsr_q = lfsr_next(lfsr_q);
      d = (d << 1) | lfsr_q[0];
    end
  endtask

  task automatic check_val(input string name, input logic [VAL_W-1:0] got,
                           input logic [VAL_W-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic set_entry(input int idx, input vec_op_e op, input int unsigned vd,
                           input int unsigned vs1, input int unsigned vs2,
                           input logic [ELEN-1:0] scalar, input logic [ELEN-1:0] exp_result,
                           input logic exp_err);
    tbl[idx].req.op     = op;
    tbl[idx].req.vd     = vreg_idx_t'(vd);
    tbl[idx].req.vs1    = vreg_idx_t'(vs1);
    tbl[idx].req.vs2    = vreg_idx_t'(vs2);
    tbl[idx].req.scalar = scalar;
    tbl[idx].req.id     = ID_WIDTH'(idx);
    tbl[idx].exp_result = exp_result;
    tbl[idx].exp_err    = exp_err;
  endtask

  // v1 = e, v2 = 3, v3 = e+3, v4 = e-3, v5 = 3e, v6 = e^3 for e in 0..7
  task automatic fill_table();
    set_entry(0,  OP_VID,     1, 0, 0, 32'd0,         32'd0,  1'b0);
    set_entry(1,  OP_VREDSUM, 0, 1, 0, 32'd0,         32'd28, 1'b0);
    set_entry(2,  OP_VEXT,    0, 1, 0, 32'd5,         32'd5,  1'b0);
    set_entry(3,  OP_VSPLAT,  2, 0, 0, 32'd3,         32'd0,  1'b0);
    set_entry(4,  OP_VADD,    3, 1, 2, 32'd0,         32'd0,  1'b0);
    set_entry(5,  OP_VEXT,    0, 3, 0, 32'd6,         32'd9,  1'b0);
    set_entry(6,  OP_VSUB,    4, 1, 2, 32'd0,         32'd0,  1'b0);
    set_entry(7,  OP_VEXT,    0, 4, 0, 32'd6,         32'd3,  1'b0);
    set_entry(8,  OP_VMUL,    5, 1, 2, 32'd0,         32'd0,  1'b0);
    set_entry(9,  OP_VEXT,    0, 5, 0, 32'd6,         32'd18, 1'b0);
    set_entry(10, OP_VXOR,    6, 1, 2, 32'd0,         32'd0,  1'b0);
    set_entry(11, OP_VEXT,    0, 6, 0, 32'd6,         32'd5,  1'b0);
    // 28 + 8*3, 28 - 8*3, 3*28, permutation of 0..7
    set_entry(12, OP_VREDSUM, 0, 3, 0, 32'd0,         32'd52, 1'b0);
    set_entry(13, OP_VREDSUM, 0, 4, 0, 32'd0,         32'd4,  1'b0);
    set_entry(14, OP_VREDSUM, 0, 5, 0, 32'd0,         32'd84, 1'b0);
    set_entry(15, OP_VREDSUM, 0, 6, 0, 32'd0,         32'd28, 1'b0);
    // Illegal requests, registers stay as they are
    set_entry(16, vec_op_e'(4'hA), 1, 2, 2, 32'd0,    32'd0,  1'b1);
    set_entry(17, OP_VEXT,    0, 1, 0, 32'd8,         32'd0,  1'b1);
    set_entry(18, OP_VREDSUM, 0, 1, 0, 32'd0,         32'd28, 1'b0);
    // Eight times 2^31 wraps to zero
    set_entry(19, OP_VSPLAT,  7, 0, 0, 32'h8000_0000, 32'd0,  1'b0);
    set_entry(20, OP_VREDSUM, 0, 7, 0, 32'd0,         32'd0,  1'b0);
  endtask

  ////////////////////////////////////////////////////////////
  // One request and its response
  ////////////////////////////////////////////////////////////

  task automatic run_entry(input int idx);
    acc_resp_t    got;
    int unsigned  lat;
    int unsigned  delay;
    int unsigned  errs_before;
    int unsigned  exp_lat;
    errs_before = errors;
    @(negedge clk_i);
    req_valid_i = 1'b1;
    req_i       = tbl[idx].req;
    while (!req_ready_o) @(negedge clk_i);
    // Accepted on the next rising edge
    @(negedge clk_i);
    req_valid_i = 1'b0;
    req_i       = '0;
    lat = 0;
    while (!resp_valid_o) begin
      check_val("req_ready_o", req_ready_o, 0);
      @(negedge clk_i);
      lat++;
    end
    exp_lat = tbl[idx].exp_err ? LAT_ILLEGAL : LAT_LEGAL;
    check_val("latency", lat, exp_lat);
    got = resp_o;
    pick_delay(delay);
    repeat (delay) begin
      check_val("req_ready_o", req_ready_o, 0);
      @(negedge clk_i);
      check_val("resp_valid_o", resp_valid_o, 1);
      check_val("resp_o", resp_o, got);
    end
    check_val("req_ready_o", req_ready_o, 0);
    resp_ready_i = 1'b1;
    @(negedge clk_i);
    resp_ready_i = 1'b0;
    check_val("resp_valid_o", resp_valid_o, 0);
    check_val("resp_o.result", got.result, tbl[idx].exp_result);
    check_val("resp_o.err", got.err, tbl[idx].exp_err);
    check_val("resp_o.id", got.id, tbl[idx].req.id);
    if (errors == errs_before) begin
      $display("entry %0d op 0x%h id %0d: pass", idx, tbl[idx].req.op, tbl[idx].req.id);
    end else begin
      failed_tests++;
      $display("entry %0d op 0x%h id %0d: fail", idx, tbl[idx].req.op, tbl[idx].req.id);
    end
  endtask

  initial begin
    rst_n_i      = 1'b0;
    req_valid_i  = 1'b0;
    req_i        = '0;
    resp_ready_i = 1'b0;
    errors       = 0;
    failed_tests = 0;
    lfsr_q       = 32'hb813;
    fill_table();
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_val("req_ready_o", req_ready_o, 1);
    check_val("resp_valid_o", resp_valid_o, 0);
    for (int i = 0; i < NUM_TESTS; i++) begin
      run_entry(i);
    end
    $display("%0d entries, %0d passed, %0d failed, %0d mismatches",
             NUM_TESTS, NUM_TESTS - failed_tests, failed_tests, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : tb_vec_system

// File: verilog/vec_system.sv
`timescale 1ns/1ps

module vec_system (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // Request port
  input  logic                 req_valid_i,
  input  vec_pkg::acc_req_t    req_i,
  output logic                 req_ready_o,
  // Response port
  output logic                 resp_valid_o,
  output vec_pkg::acc_resp_t   resp_o,
  input  logic                 resp_ready_i
);

  import vec_pkg::*;

  logic                          cmd_valid;
  lane_cmd_t                     cmd;
  logic                          start;
  logic                          err_start;
  logic [ID_WIDTH-1:0]           id;
  logic [NR_LANES-1:0]           lane_idle;
  logic [NR_LANES-1:0]           lane_done;
  lane_part_t [NR_LANES-1:0]     lane_part;
  logic                          lanes_idle;
  logic                          coll_idle;

  assign lanes_idle = &lane_idle;

  vec_dispatcher i_dispatcher (
    .clk_i        (clk_i       ),
    .rst_n_i      (rst_n_i     ),
    .req_valid_i  (req_valid_i ),
    .req_i        (req_i       ),
    .req_ready_o  (req_ready_o ),
    .lanes_idle_i (lanes_idle  ),
    .coll_idle_i  (coll_idle   ),
    .cmd_valid_o  (cmd_valid   ),
    .cmd_o        (cmd         ),
    .start_o      (start       ),
    .err_start_o  (err_start   ),
    .id_o         (id          )
  );

  ////////////////////////////////////////////////////////////
  // Lanes
  ////////////////////////////////////////////////////////////

  for (genvar l = 0; l < NR_LANES; l++) begin : gen_lanes
    vec_lane #(
      .LaneIdx (l)
    ) i_lane (
      .clk_i       (clk_i       ),
      .rst_n_i     (rst_n_i     ),
      .cmd_valid_i (cmd_valid   ),
      .cmd_i       (cmd         ),
      .idle_o      (lane_idle[l]),
      .done_o      (lane_done[l]),
      .part_o      (lane_part[l])
    );
  end

  vec_collector i_collector (
    .clk_i        (clk_i       ),
    .rst_n_i      (rst_n_i     ),
    .start_i      (start       ),
    .err_start_i  (err_start   ),
    .id_i         (id          ),
    .done_i       (lane_done   ),
    .parts_i      (lane_part   ),
    .resp_ready_i (resp_ready_i),
    .resp_valid_o (resp_valid_o),
    .resp_o       (resp_o      ),
    .idle_o       (coll_idle   )
  );

endmodule : vec_system

// File: verilog/vec_collector.sv
`timescale 1ns/1ps

module vec_collector (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  input  logic                                          start_i,
  input  logic                                          err_start_i,
  input  logic [vec_pkg::ID_WIDTH-1:0]                  id_i,
  input  logic [vec_pkg::NR_LANES-1:0]                  done_i,
  input  vec_pkg::lane_part_t [vec_pkg::NR_LANES-1:0]   parts_i,
  input  logic                                          resp_ready_i,
  output logic                                          resp_valid_o,
  output vec_pkg::acc_resp_t                            resp_o,
  output logic                                          idle_o
);

  import vec_pkg::*;

  logic                 pending_q;
  logic                 resp_valid_q;
  logic [ID_WIDTH-1:0]  id_q;
  acc_resp_t            resp_q;

  logic [ELEN-1:0]      part_sum;
  logic [ELEN-1:0]      ext_elem;
  logic                 any_hit;
  logic [ELEN-1:0]      combined;
  logic                 all_done;

  ////////////////////////////////////////////////////////////
  // Combine partials
  ////////////////////////////////////////////////////////////

  // Lanes hold zero partials for element-wise ops
  always_comb begin
    part_sum = '0;
    ext_elem = '0;
    any_hit  = 1'b0;
    for (int l = 0; l < NR_LANES; l++) begin
      part_sum = part_sum + parts_i[l].data;
      if (parts_i[l].hit) begin
        any_hit  = 1'b1;
        ext_elem = parts_i[l].data;
      end
    end
  end

  assign combined = any_hit ? ext_elem : part_sum;
  assign all_done = &done_i;

  ////////////////////////////////////////////////////////////
  // Response register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q    <= 1'b0;
      resp_valid_q <= 1'b0;
    end else begin
      if (resp_valid_q && resp_ready_i) begin
        resp_valid_q <= 1'b0;
      end
      if (start_i) begin
        pending_q <= 1'b1;
      end
      if (err_start_i) begin
        resp_valid_q <= 1'b1;
      end else if (pending_q && all_done) begin
        pending_q    <= 1'b0;
        resp_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      id_q <= id_i;
    end
    if (err_start_i) begin
      resp_q <= '{result: '0, err: 1'b1, id: id_i};
    end else if (pending_q && all_done) begin
      resp_q <= '{result: combined, err: 1'b0, id: id_q};
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_o       = resp_q;
  assign idle_o       = ~pending_q & ~resp_valid_q;

  // Lanes run in lockstep
  a_done_lockstep: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (done_i == '0) || all_done);

endmodule : vec_collector

// File: verilog/vec_lane.sv
`timescale 1ns/1ps

module vec_lane #(
  parameter int unsigned LaneIdx = 0
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 cmd_valid_i,
  input  vec_pkg::lane_cmd_t   cmd_i,
  output logic                 idle_o,
  output logic                 done_o,
  output vec_pkg::lane_part_t  part_o
);

  import vec_pkg::*;

  lane_state_e        state_q;
  logic [SLOT_W-1:0]  slot_q;
  lane_cmd_t          cmd_q;
  lane_part_t         part_q;
  logic [ELEN-1:0]    vrf_q [NR_VREGS][ELEMS_PER_LANE];

  logic [ELEN-1:0]    elem_idx;
  logic [ELEN-1:0]    op_a;
  logic [ELEN-1:0]    op_b;
  logic [ELEN-1:0]    alu_res;
  logic               alu_we;

  // Global element number of the current slot
  assign elem_idx = ELEN'(slot_q) * ELEN'(NR_LANES) + ELEN'(LaneIdx);
  assign op_a     = vrf_q[cmd_q.vs1][slot_q];
  assign op_b     = vrf_q[cmd_q.vs2][slot_q];

  ////////////////////////////////////////////////////////////
  // Element ALU
  ////////////////////////////////////////////////////////////

  always_comb begin
    alu_res = '0;
    alu_we  = 1'b1;
    case (cmd_q.op)
      OP_VID:    alu_res = elem_idx;
      OP_VSPLAT: alu_res = cmd_q.scalar;
      OP_VADD:   alu_res = op_a + op_b;
      OP_VSUB:   alu_res = op_a - op_b;
      OP_VMUL:   alu_res = op_a * op_b;
      OP_VXOR:   alu_res = op_a ^ op_b;
      // Reductions and extracts leave the registers alone
      default:   alu_we = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int r = 0; r < NR_VREGS; r++) begin
        for (int s = 0; s < ELEMS_PER_LANE; s++) begin
          vrf_q[r][s] <= '0;
        end
      end
    end else if (state_q == LANE_EXEC && alu_we) begin
      vrf_q[cmd_q.vd][slot_q] <= alu_res;
    end
  end

  ////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (state_q == LANE_IDLE && cmd_valid_i) begin
      cmd_q <= cmd_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= LANE_IDLE;
      slot_q  <= '0;
      part_q  <= '0;
    end else begin
      case (state_q)
        LANE_IDLE: begin
          if (cmd_valid_i) begin
            state_q <= LANE_EXEC;
            slot_q  <= '0;
            part_q  <= '0;
          end
        end
        LANE_EXEC: begin
          if (cmd_q.op == OP_VREDSUM) begin
            part_q.data <= part_q.data + op_a;
          end
          if (cmd_q.op == OP_VEXT && elem_idx == cmd_q.scalar) begin
            part_q.hit  <= 1'b1;
            part_q.data <= op_a;
          end
          if (slot_q == SLOT_W'(ELEMS_PER_LANE - 1)) begin
            state_q <= LANE_DONE;
          end else begin
            slot_q <= slot_q + 1'b1;
          end
        end
        default: state_q <= LANE_IDLE;
      endcase
    end
  end

  assign idle_o = (state_q == LANE_IDLE);
  assign done_o = (state_q == LANE_DONE);
  assign part_o = part_q;

  a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    done_o |-> $past(state_q == LANE_EXEC) ##1 !done_o);

endmodule : vec_lane

// File: verilog/vec_dispatcher.sv
`timescale 1ns/1ps

module vec_dispatcher (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // Scalar-side request port
  input  logic                          req_valid_i,
  input  vec_pkg::acc_req_t             req_i,
  output logic                          req_ready_o,
  // Status from the back end
  input  logic                          lanes_idle_i,
  input  logic                          coll_idle_i,
  // Lane broadcast
  output logic                          cmd_valid_o,
  output vec_pkg::lane_cmd_t            cmd_o,
  // Collector start
  output logic                          start_o,
  output logic                          err_start_o,
  output logic [vec_pkg::ID_WIDTH-1:0]  id_o
);

  import vec_pkg::*;

  logic                 busy_q;
  logic                 ready;
  logic                 accept;
  logic                 legal;
  logic                 cmd_valid_q;
  logic                 err_start_q;
  lane_cmd_t            cmd_q;
  logic [ID_WIDTH-1:0]  id_q;

  // Busy covers the cycle before lanes or collector report activity
  assign ready  = lanes_idle_i & coll_idle_i & ~busy_q;
  assign accept = req_valid_i & ready;

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (req_i.op)
      OP_VID, OP_VSPLAT, OP_VADD, OP_VSUB,
      OP_VMUL, OP_VXOR, OP_VREDSUM: legal = 1'b1;
      // Index must address an existing element
      OP_VEXT: legal = (req_i.scalar < ELEN'(NR_ELEMS));
      default: legal = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Registered broadcast
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q      <= 1'b0;
      cmd_valid_q <= 1'b0;
      err_start_q <= 1'b0;
    end else begin
      busy_q      <= accept;
      cmd_valid_q <= accept & legal;
      err_start_q <= accept & ~legal;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      cmd_q <= '{op: req_i.op, vd: req_i.vd, vs1: req_i.vs1, vs2: req_i.vs2,
                 scalar: req_i.scalar};
      id_q  <= req_i.id;
    end
  end

  assign req_ready_o = ready;
  assign cmd_valid_o = cmd_valid_q;
  assign cmd_o       = cmd_q;
  assign start_o     = cmd_valid_q;
  assign err_start_o = err_start_q;
  assign id_o        = id_q;

  // Lanes must still be idle when the broadcast lands
  a_cmd_lanes_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cmd_valid_o |-> lanes_idle_i);

endmodule : vec_dispatcher

// File: verilog/vec_pkg.sv
package vec_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////

  localparam int unsigned NR_LANES       = 4;
  localparam int unsigned ELEMS_PER_LANE = 2;
  // Element e sits in lane e mod NR_LANES, slot e div NR_LANES
  localparam int unsigned NR_ELEMS       = NR_LANES * ELEMS_PER_LANE;
  localparam int unsigned NR_VREGS       = 8;
  localparam int unsigned VREG_W         = $clog2(NR_VREGS);
  localparam int unsigned ELEN           = 32;
  localparam int unsigned ID_WIDTH       = 3;
  localparam int unsigned SLOT_W         = (ELEMS_PER_LANE > 1) ? $clog2(ELEMS_PER_LANE) : 1;

  ////////////////////////////////////////////////////////////
  // Opcodes and states
  ////////////////////////////////////////////////////////////

  // Encodings 8 to 15 are illegal
  typedef enum logic [3:0] {
    OP_VID     = 4'd0,
    OP_VSPLAT  = 4'd1,
    OP_VADD    = 4'd2,
    OP_VSUB    = 4'd3,
    OP_VMUL    = 4'd4,
    OP_VXOR    = 4'd5,
    OP_VREDSUM = 4'd6,
    OP_VEXT    = 4'd7
  } vec_op_e;

  typedef enum logic [1:0] {
    LANE_IDLE = 2'd0,
    LANE_EXEC = 2'd1,
    LANE_DONE = 2'd2
  } lane_state_e;

  ////////////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////////////

  typedef logic [VREG_W-1:0] vreg_idx_t;

  typedef struct packed {
    vec_op_e               op;
    vreg_idx_t             vd;
    vreg_idx_t             vs1;
    vreg_idx_t             vs2;
    logic [ELEN-1:0]       scalar;
    logic [ID_WIDTH-1:0]   id;
  } acc_req_t;

  typedef struct packed {
    logic [ELEN-1:0]       result;
    logic                  err;
    logic [ID_WIDTH-1:0]   id;
  } acc_resp_t;

  typedef struct packed {
    vec_op_e               op;
    vreg_idx_t             vd;
    vreg_idx_t             vs1;
    vreg_idx_t             vs2;
    logic [ELEN-1:0]       scalar;
  } lane_cmd_t;

  // Reduction sum, or extracted element with hit set
  typedef struct packed {
    logic [ELEN-1:0]       data;
    logic                  hit;
  } lane_part_t;

endpackage : vec_pkg
